//--- verilog/stream_bridge_cfg.svh
/*
 * Build-time configuration of the stream bridge: beat geometry, FIFO depth, lane order.
 */

`ifndef STREAM_BRIDGE_CFG_SVH
`define STREAM_BRIDGE_CFG_SVH

// ============================================================
// beat geometry
// ============================================================
`define STREAM_DATA_WIDTH   32  // beat width in bits.
`define STREAM_KEEP_WIDTH   4   // one keep bit per byte lane.
`define STREAM_EMPTY_WIDTH  2   // enough to count the unused lanes of a beat.

// ============================================================
// buffering and lane order
// ============================================================
`define STREAM_FIFO_DEPTH   4   // beats held between the two converters.
`define STREAM_BYTE_REVERSE 1   // 1 swaps byte lanes in both converters.

`endif

//--- verilog/stream_bridge_pkg.sv
/*
 * Shared beat types for the stream bridge: data word, keep mask, empty count.
 */

`include "stream_bridge_cfg.svh"

package stream_bridge_pkg;

    // ============================================================
    // beat fields
    // ============================================================

    // one full beat of payload, lane 0 in the low byte.
    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_data_t;

    // AXI-Stream byte enables, one bit per lane.
    typedef logic [`STREAM_KEEP_WIDTH-1:0] stream_keep_t;

    // Avalon-ST empty count, only meaningful on the last beat of a packet.
    typedef logic [`STREAM_EMPTY_WIDTH-1:0] stream_empty_t;

endpackage

//--- verilog/avst_if.sv
/*
 * Avalon-ST beat channel with source and sink views.
 */

`timescale 1ns/1ns

interface avst_if import stream_bridge_pkg::*; ();

    // ============================================================
    // channel signals
    // ============================================================
    logic          valid;          // source holds the beat until ready is seen.
    stream_data_t  data;           // payload lanes.
    logic          startofpacket;  // first beat of a packet.
    logic          endofpacket;    // last beat of a packet.
    stream_empty_t empty;          // unused lanes in the last beat.
    logic          error;          // packet is marked bad.
    logic          ready;          // sink can take a beat this cycle.

    // the source drives the beat and watches ready.
    modport source (
        output valid, data, startofpacket, endofpacket, empty, error,
        input  ready
    );

    // the sink takes the beat and drives ready from its own state.
    modport sink (
        input  valid, data, startofpacket, endofpacket, empty, error,
        output ready
    );

endinterface

//--- verilog/axis_to_avst.sv
/*
 * AXI-Stream to Avalon-ST converter with frame tracking for start of packet,
 * empty count from the top keep bit and optional byte lane reversal.
 */

`timescale 1ns/1ns
`include "stream_bridge_cfg.svh"

module axis_to_avst import stream_bridge_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  stream_data_t in_tdata,
    input  stream_keep_t in_tkeep,
    input  logic         in_tvalid,
    input  logic         in_tlast,
    input  logic         in_tuser,
    output logic         in_tready,
    avst_if.source       avst
);

    localparam int BYTE_W = `STREAM_DATA_WIDTH / `STREAM_KEEP_WIDTH; // bits per lane.

    logic frame_reg; // set while inside a packet, so no start of packet is due.

    // ============================================================
    // data path
    // ============================================================
    always_comb begin
        int k;
        avst.empty = stream_empty_t'(`STREAM_KEEP_WIDTH - 1); // zero keep counts as one byte.
        for (k = 0; k < `STREAM_KEEP_WIDTH; k++) begin
            if (in_tkeep[k]) begin
                avst.empty = stream_empty_t'(`STREAM_KEEP_WIDTH - 1 - k); // last hit is the top lane.
            end
        end
    end

    always_comb begin
        int n;
        avst.data = in_tdata; // straight lanes unless reversal is on.
        if (`STREAM_BYTE_REVERSE != 0) begin
            for (n = 0; n < `STREAM_KEEP_WIDTH; n++) begin
                // lane n takes the mirrored input lane.
                avst.data[n*BYTE_W +: BYTE_W] =
                    in_tdata[(`STREAM_KEEP_WIDTH-1-n)*BYTE_W +: BYTE_W];
            end
        end
    end

    assign avst.valid         = in_tvalid;               // beat is offered as soon as it arrives.
    assign avst.startofpacket = in_tvalid & ~frame_reg;  // first beat after reset or a last beat.
    assign avst.endofpacket   = in_tlast;                // packet boundaries line up one to one.
    assign avst.error         = in_tuser;                // tuser carries the bad-packet mark.
    assign in_tready          = avst.ready;              // no buffering here.

    // ============================================================
    // frame state
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg <= 1'b0;                   // next beat opens a packet.
        end else if (in_tvalid && in_tready) begin
            frame_reg <= ~in_tlast;              // a last beat closes the frame.
        end
    end

endmodule

//--- verilog/avst_fifo.sv
/*
 * Register FIFO of complete Avalon-ST beats with ready-based flow control.
 */

`timescale 1ns/1ns
`include "stream_bridge_cfg.svh"

module avst_fifo import stream_bridge_pkg::*; (
    input  logic clk,
    input  logic rst,
    avst_if.sink   wr,
    avst_if.source rd
);

    localparam int PTR_W = $clog2(`STREAM_FIFO_DEPTH);     // index into the entry array.
    localparam int CNT_W = $clog2(`STREAM_FIFO_DEPTH + 1); // occupancy from 0 to full.

    // ============================================================
    // storage
    // ============================================================
    stream_data_t  mem_data  [`STREAM_FIFO_DEPTH]; // payload of each entry.
    stream_empty_t mem_empty [`STREAM_FIFO_DEPTH]; // empty count of each entry.
    logic          mem_sop   [`STREAM_FIFO_DEPTH]; // start of packet marker.
    logic          mem_eop   [`STREAM_FIFO_DEPTH]; // end of packet marker.
    logic          mem_err   [`STREAM_FIFO_DEPTH]; // error marker.

    logic [PTR_W-1:0] wr_ptr;  // next entry to fill.
    logic [PTR_W-1:0] rd_ptr;  // oldest entry held.
    logic [CNT_W-1:0] count;   // entries currently held.
    logic             wr_fire; // a beat enters this cycle.
    logic             rd_fire; // a beat leaves this cycle.

    // step a pointer around the ring. The depth need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`STREAM_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ============================================================
    // handshake
    // ============================================================
    assign wr.ready = (count < CNT_W'(`STREAM_FIFO_DEPTH)); // own occupancy only.
    assign rd.valid = (count != '0);                        // something is held.
    assign wr_fire  = wr.valid & wr.ready;
    assign rd_fire  = rd.valid & rd.ready;

    // the head entry is shown directly.
    assign rd.data          = mem_data[rd_ptr];
    assign rd.empty         = mem_empty[rd_ptr];
    assign rd.startofpacket = mem_sop[rd_ptr];
    assign rd.endofpacket   = mem_eop[rd_ptr];
    assign rd.error         = mem_err[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem_data[wr_ptr]  <= wr.data;
            mem_empty[wr_ptr] <= wr.empty;
            mem_sop[wr_ptr]   <= wr.startofpacket;
            mem_eop[wr_ptr]   <= wr.endofpacket;
            mem_err[wr_ptr]   <= wr.error;
        end
    end

    // ============================================================
    // pointers and occupancy
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                                // empty, so rd valid is low.
        end else begin
            if (wr_fire) wr_ptr <= next_ptr(wr_ptr);
            if (rd_fire) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;          // fill only.
                2'b01:   count <= count - 1'b1;          // drain only.
                default: count <= count;                 // both or neither leave it.
            endcase
        end
    end

endmodule

//--- verilog/avst_to_axis.sv
/*
 * Avalon-ST to AXI-Stream converter: empty count back to a contiguous keep mask,
 * byte lane reversal undone, packet markers mapped to tlast and tuser.
 */

`timescale 1ns/1ns
`include "stream_bridge_cfg.svh"

module avst_to_axis import stream_bridge_pkg::*; (
    avst_if.sink         avst,
    output stream_data_t out_tdata,
    output stream_keep_t out_tkeep,
    output logic         out_tvalid,
    output logic         out_tlast,
    output logic         out_tuser,
    input  logic         out_tready
);

    localparam int BYTE_W = `STREAM_DATA_WIDTH / `STREAM_KEEP_WIDTH; // bits per lane.

    // ============================================================
    // keep decode
    // ============================================================

    // lane k is valid when it lies below the unused top lanes.
    always_comb begin
        int k;
        for (k = 0; k < `STREAM_KEEP_WIDTH; k++) begin
            out_tkeep[k] = (k + int'(avst.empty)) < `STREAM_KEEP_WIDTH;
        end
    end

    // ============================================================
    // lane order
    // ============================================================
    always_comb begin
        int n;
        out_tdata = avst.data; // straight lanes unless reversal is on.
        if (`STREAM_BYTE_REVERSE != 0) begin
            for (n = 0; n < `STREAM_KEEP_WIDTH; n++) begin
                // mirror again, which restores the original order.
                out_tdata[n*BYTE_W +: BYTE_W] =
                    avst.data[(`STREAM_KEEP_WIDTH-1-n)*BYTE_W +: BYTE_W];
            end
        end
    end

    // ============================================================
    // markers and handshake
    // ============================================================

    // start of packet has no AXI-Stream field. It follows from the previous tlast.
    assign out_tvalid = avst.valid;        // beat offered as soon as the FIFO shows it.
    assign out_tlast  = avst.endofpacket;  // packet end maps across unchanged.
    assign out_tuser  = avst.error;        // error mark rides in tuser.
    assign avst.ready = out_tready;        // the downstream sink paces the FIFO.

endmodule

//--- verilog/stream_bridge_top.sv
/*
 * Stream bridge top level: AXI-Stream in, Avalon-ST FIFO, AXI-Stream out.
 */

`timescale 1ns/1ns

module stream_bridge_top import stream_bridge_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    // ============================================================
    // AXI-Stream input
    // ============================================================
    input  stream_data_t in_tdata,
    input  stream_keep_t in_tkeep,
    input  logic         in_tvalid,
    input  logic         in_tlast,
    input  logic         in_tuser,
    output logic         in_tready,
    // ============================================================
    // AXI-Stream output
    // ============================================================
    output stream_data_t out_tdata,
    output stream_keep_t out_tkeep,
    output logic         out_tvalid,
    output logic         out_tlast,
    output logic         out_tuser,
    input  logic         out_tready
);

    avst_if conv_in ();  // input converter to FIFO.
    avst_if conv_out (); // FIFO to output converter.

    // incoming beats gain Avalon-ST markers here.
    axis_to_avst axis_to_avst_inst (
        .clk       (clk),
        .rst       (rst),
        .in_tdata  (in_tdata),
        .in_tkeep  (in_tkeep),
        .in_tvalid (in_tvalid),
        .in_tlast  (in_tlast),
        .in_tuser  (in_tuser),
        .in_tready (in_tready),
        .avst      (conv_in.source)
    );

    // buffering absorbs output back-pressure for a few beats.
    avst_fifo avst_fifo_inst (
        .clk (clk),
        .rst (rst),
        .wr  (conv_in.sink),
        .rd  (conv_out.source)
    );

    // beats leave as AXI-Stream with a normalized keep.
    avst_to_axis avst_to_axis_inst (
        .avst       (conv_out.sink),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser),
        .out_tready (out_tready)
    );

endmodule

//--- verification/stream_bridge_tb.sv
/*
 * Self-checking testbench for the stream bridge: reference keep model,
 * directed and random packet stimulus, in-order comparison of output beats.
 */

`timescale 1ns/1ns

module stream_bridge_tb import stream_bridge_pkg::*; ();

    localparam int TIMEOUT      = 1000; // cycles any single wait may last.
    localparam int RANDOM_BEATS = 400;  // beats in the random traffic phase.

    // one expected output beat, kept in input order.
    typedef struct packed {
        stream_data_t data;
        stream_keep_t keep;
        logic         last;
        logic         user;
        logic         sop;  // first beat of its packet.
    } beat_t;

    logic         clk;
    logic         rst;
    stream_data_t in_tdata;
    stream_keep_t in_tkeep;
    logic         in_tvalid;
    logic         in_tlast;
    logic         in_tuser;
    logic         in_tready;
    stream_data_t out_tdata;
    stream_keep_t out_tkeep;
    logic         out_tvalid;
    logic         out_tlast;
    logic         out_tuser;
    logic         out_tready;
    int           ready_mode;     // 0 holds out_tready low, 1 holds it high, 2 randomizes it.
    int           seed;           // shared state of every $random call.
    logic         in_frame;       // an accepted packet is still open at the input.
    beat_t        expected_q [$]; // accepted beats still waiting to come out.

    stream_bridge_top stream_bridge_top_inst (.*);

    always #5 clk = ~clk; // 10 ns period.

    // ============================================================
    // reference model and checks
    // ============================================================

    // lane i survives when any input lane at or above i was enabled. Lane 0 always does.
    function automatic stream_keep_t expected_keep(input stream_keep_t keep);
        stream_keep_t mask;
        mask = stream_keep_t'(1);
        for (int i = 1; i < $bits(stream_keep_t); i++) begin
            if ((keep >> i) != '0) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input stream_data_t got,
                              input stream_data_t want);
        if (got !== want) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_keep(input string name, input stream_keep_t got,
                              input stream_keep_t want);
        if (got !== want) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, want));
        end
    endtask

    // every accepted input beat becomes one expected output beat.
    always @(posedge clk) begin
        beat_t beat;
        if (!rst && in_tvalid && in_tready) begin
            beat.data = in_tdata;                // the two lane reversals cancel.
            beat.keep = expected_keep(in_tkeep); // keep comes out normalized.
            beat.last = in_tlast;
            beat.user = in_tuser;
            beat.sop  = !in_frame;               // opens a packet after reset or a last beat.
            expected_q.push_back(beat);
            in_frame <= !in_tlast;
        end
    end

    // every output transfer must match the oldest outstanding beat.
    always @(posedge clk) begin
        beat_t want;
        if (!rst && out_tvalid && out_tready) begin
            if (expected_q.size() == 0) begin
                report_failure("an output beat appeared with no input beat outstanding");
            end else begin
                want = expected_q.pop_front();
                check_data("out_tdata", out_tdata, want.data);
                check_keep("out_tkeep", out_tkeep, want.keep);
                check_flag("out_tlast", out_tlast, want.last);
                check_flag("out_tuser", out_tuser, want.user);
                // start of packet only exists on the channel into the output converter.
                check_flag("conv_out.startofpacket",
                           stream_bridge_top_inst.conv_out.startofpacket, want.sop);
            end
        end
    end

    // the downstream sink, paced by ready_mode.
    always @(posedge clk) begin
        case (ready_mode)
            1:       out_tready <= 1'b1;
            2:       out_tready <= ($random(seed) & 1) != 0; // ready about half the time.
            default: out_tready <= 1'b0;
        endcase
    end

    // ============================================================
    // stimulus tasks
    // ============================================================
    task automatic drive_beat(input stream_data_t data, input stream_keep_t keep,
                              input logic last, input logic user);
        in_tdata  <= data;
        in_tkeep  <= keep;
        in_tlast  <= last;
        in_tuser  <= user;
        in_tvalid <= 1'b1; // held until the bridge takes it.
    endtask

    // returns on the edge where the offered beat transfers.
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_tready && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!in_tready) begin
            report_failure("timed out waiting for in_tready to accept a beat");
        end
    endtask

    task automatic send_beat(input stream_data_t data, input stream_keep_t keep,
                             input logic last, input logic user);
        drive_beat(data, keep, last, user);
        wait_accept();
    endtask

    task automatic idle_cycle();
        in_tvalid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            report_failure("timed out waiting for the output to drain");
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int sent;
        int len;
        clk        = 1'b0;
        rst        = 1'b1;
        in_tdata   = '0;
        in_tkeep   = '0;
        in_tvalid  = 1'b0;
        in_tlast   = 1'b0;
        in_tuser   = 1'b0;
        out_tready = 1'b0;
        ready_mode = 0;
        in_frame   = 1'b0;
        seed       = 32'ha8a6_3b39;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("out_tvalid", out_tvalid, 1'b0); // FIFO starts empty.
        check_flag("in_tready", in_tready, 1'b1);

        // back-to-back packets with every kind of keep, including none at all.
        ready_mode <= 1;
        send_beat(32'h0302_0100, 4'b0000, 1'b1, 1'b0);
        send_beat(32'h1312_1110, 4'b1111, 1'b0, 1'b0);
        send_beat(32'h2322_2120, 4'b0101, 1'b0, 1'b1);
        send_beat(32'h3332_3130, 4'b0001, 1'b1, 1'b1);
        send_beat(32'h4342_4140, 4'b1000, 1'b0, 1'b0);
        send_beat(32'h5352_5150, 4'b0110, 1'b1, 1'b0);
        send_beat(32'h6362_6160, 4'b0011, 1'b1, 1'b1);
        idle_cycle();
        wait_drained();

        // with the output stalled, four beats fill the FIFO and the fifth waits.
        ready_mode <= 0;
        repeat (2) idle_cycle();
        for (int i = 0; i < 4; i++) begin
            send_beat($random(seed), stream_keep_t'($random(seed)), i == 3, 1'($random(seed)));
        end
        drive_beat(32'hcafe_f00d, 4'b0111, 1'b1, 1'b1);
        repeat (4) begin
            @(posedge clk);
            check_flag("in_tready", in_tready, 1'b0); // full until the output moves.
        end
        ready_mode <= 1;
        wait_accept();
        idle_cycle();
        wait_drained();

        // random packets against a random output sink.
        ready_mode <= 2;
        sent = 0;
        while (sent < RANDOM_BEATS) begin
            len = 1 + ($random(seed) & 7);
            for (int i = 0; i < len; i++) begin
                if (($random(seed) & 3) == 0) begin
                    idle_cycle(); // gap in the input stream.
                end
                send_beat($random(seed), stream_keep_t'($random(seed)), i == len - 1,
                          1'($random(seed)));
                sent++;
            end
        end
        idle_cycle();
        ready_mode <= 1;
        wait_drained();
        repeat (4) begin
            @(posedge clk);
            check_flag("out_tvalid", out_tvalid, 1'b0); // nothing extra follows.
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- stream_bridge_top.f
+incdir+verilog
verilog/stream_bridge_pkg.sv
verilog/avst_if.sv
verilog/axis_to_avst.sv
verilog/avst_fifo.sv
verilog/avst_to_axis.sv
verilog/stream_bridge_top.sv
verification/stream_bridge_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= stream_bridge_tb
LINT_TOP   ?= stream_bridge_top
FILELIST   ?= stream_bridge_top.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := NO ERRORS
SOURCES    := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the simulator output.
run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
